/* logic/fru_pkg.sv */
/*
 * Filter-reduce stage shared definitions
 * Sizes, vector types and the configuration state encoding
 */
package fru_pkg;

  // ----------------------------------------------------------------------
  // Sizes
  // ----------------------------------------------------------------------
  localparam int LANES      = 8;
  localparam int BINS       = 4;
  localparam int DATA_WIDTH = 32;
  localparam int MAX_CHAINS = 4;
  localparam int EDGE_ROWS  = 4;

  // Bytes in one packed edge row
  localparam int ROW_BYTES  = BINS * DATA_WIDTH / 8;

  // ----------------------------------------------------------------------
  // Vector types
  // ----------------------------------------------------------------------
  typedef logic [DATA_WIDTH-1:0]          data_t;
  typedef logic [$clog2(MAX_CHAINS)-1:0]  chain_id_t;
  typedef logic [$clog2(EDGE_ROWS)-1:0]   edge_addr_t;

  // Bin 0 sits in the most significant word
  typedef logic [BINS*DATA_WIDTH-1:0]     edge_row_t;

  // Wide enough to hold LANES matches
  typedef logic [$clog2(LANES+1)-1:0]     count_t;

  typedef logic [1:0]                     marker_t;
  typedef logic [7:0]                     cfg_byte_t;

  // Configuration stream walk
  typedef enum logic [1:0] {
    CFG_TABLES,
    CFG_EDGES,
    CFG_DONE
  } cfg_state_t;

  // ----------------------------------------------------------------------
  // Table encodings
  // ----------------------------------------------------------------------
  // Id this unit answers to on the config bus
  localparam cfg_byte_t CONFIG_ID    = 8'd0;

  // Filter op that routes a beat through the reduce path
  localparam cfg_byte_t OP_REDUCE    = 8'd1;

  // Reduce axis that counts per bin across lanes
  localparam cfg_byte_t AXIS_PER_BIN = 8'd2;

endpackage

/* logic/bin_edge_ram.sv */
/*
 * Bin edge memory
 * One read port and one write port, registered read
 */
`timescale 1ns/1ps

module bin_edge_ram (
  input  logic                clk,
  input  fru_pkg::edge_addr_t rd_addr,
  output fru_pkg::edge_row_t  rd_row,
  input  logic                wr_en,
  input  fru_pkg::edge_addr_t wr_addr,
  input  fru_pkg::edge_row_t  wr_row
);
  import fru_pkg::*;

  edge_row_t mem [EDGE_ROWS];

  // Write port
  always_ff @(posedge clk) begin
    if (wr_en) begin
      mem[wr_addr] <= wr_row;
    end
  end

  // Read port, a same-row write in this cycle still returns the old row
  always_ff @(posedge clk) begin
    rd_row <= mem[rd_addr];
  end

endmodule

/* logic/fru_config_loader.sv */
/*
 * Configuration loader
 * Walks the config byte stream into the per-chain tables and edge rows
 */
`timescale 1ns/1ps

module fru_config_loader (
  input  logic                clk,
  input  logic                reset,
  input  logic                tracing,
  input  fru_pkg::cfg_byte_t  config_id,
  input  fru_pkg::cfg_byte_t  config_data,
  input  fru_pkg::chain_id_t  lookup_chain,
  output fru_pkg::cfg_byte_t  filter_op,
  output fru_pkg::cfg_byte_t  edge_addr,
  output fru_pkg::cfg_byte_t  reduce_axis,
  output logic                edge_wr_en,
  output fru_pkg::edge_addr_t edge_wr_addr,
  output fru_pkg::edge_row_t  edge_wr_row
);
  import fru_pkg::*;

  cfg_state_t                       state;
  logic [$clog2(3*MAX_CHAINS)-1:0]  tbl_cnt;
  logic [$clog2(ROW_BYTES)-1:0]     byte_cnt;
  edge_addr_t                       row_cnt;
  edge_row_t                        row_shift;
  edge_row_t                        next_row;
  chain_id_t                        tbl_slot;
  logic                             cfg_cycle;

  cfg_byte_t op_tbl   [MAX_CHAINS];
  cfg_byte_t addr_tbl [MAX_CHAINS];
  cfg_byte_t axis_tbl [MAX_CHAINS];

  assign cfg_cycle = !tracing && (config_id == CONFIG_ID);

  // Chain slot within the current table
  assign tbl_slot = chain_id_t'(tbl_cnt % MAX_CHAINS);

  // Row with the incoming byte shifted in at the bottom
  assign next_row = {row_shift[ROW_BYTES*8-9:0], config_data};

  // ----------------------------------------------------------------------
  // Stream FSM and tables
  // ----------------------------------------------------------------------
  always_ff @(posedge clk) begin
    if (reset) begin
      state      <= CFG_TABLES;
      tbl_cnt    <= '0;
      byte_cnt   <= '0;
      row_cnt    <= '0;
      edge_wr_en <= 1'b0;
      for (int c = 0; c < MAX_CHAINS; c++) begin
        op_tbl[c]   <= '0;
        addr_tbl[c] <= '0;
        axis_tbl[c] <= '0;
      end
    end else begin
      edge_wr_en <= 1'b0;
      if (!cfg_cycle) begin
        // Stream broken, next config byte is byte 0 again
        state    <= CFG_TABLES;
        tbl_cnt  <= '0;
        byte_cnt <= '0;
        row_cnt  <= '0;
      end else begin
        case (state)
          CFG_TABLES: begin
            if (tbl_cnt < MAX_CHAINS) begin
              op_tbl[tbl_slot] <= config_data;
            end else if (tbl_cnt < 2*MAX_CHAINS) begin
              addr_tbl[tbl_slot] <= config_data;
            end else begin
              axis_tbl[tbl_slot] <= config_data;
            end
            if (tbl_cnt == 3*MAX_CHAINS-1) begin
              tbl_cnt <= '0;
              state   <= CFG_EDGES;
            end else begin
              tbl_cnt <= tbl_cnt + 1'b1;
            end
          end
          CFG_EDGES: begin
            if (byte_cnt == ROW_BYTES-1) begin
              byte_cnt   <= '0;
              edge_wr_en <= 1'b1;
              row_cnt    <= row_cnt + 1'b1;
              if (row_cnt == EDGE_ROWS-1) begin
                state <= CFG_DONE;
              end
            end else begin
              byte_cnt <= byte_cnt + 1'b1;
            end
          end
          // All rows loaded, extra bytes dropped
          default: begin
          end
        endcase
      end
    end
  end

  // Edge row assembly, written out with its last byte
  always_ff @(posedge clk) begin
    if (cfg_cycle && state == CFG_EDGES) begin
      row_shift <= next_row;
      if (byte_cnt == ROW_BYTES-1) begin
        edge_wr_row  <= next_row;
        edge_wr_addr <= row_cnt;
      end
    end
  end

  // Lookups for the incoming chain
  assign filter_op   = op_tbl[lookup_chain];
  assign edge_addr   = addr_tbl[lookup_chain];
  assign reduce_axis = axis_tbl[lookup_chain];

endmodule

/* logic/bin_filter.sv */
/*
 * Bin filter
 * Compares every lane of a beat against every bin of an edge row
 */
`timescale 1ns/1ps

module bin_filter (
  input  fru_pkg::data_t                                beat [fru_pkg::LANES-1:0],
  input  fru_pkg::edge_row_t                            edges,
  output logic [fru_pkg::BINS-1:0][fru_pkg::LANES-1:0]  match
);
  import fru_pkg::*;

  data_t edge_val [BINS];
  data_t upper    [BINS];

  // Unpack the row, bin 0 from the top word
  always_comb begin
    for (int j = 0; j < BINS; j++) begin
      edge_val[j] = edges[(BINS-1-j)*DATA_WIDTH +: DATA_WIDTH];
    end
  end

  // ----------------------------------------------------------------------
  // Upper bounds
  // ----------------------------------------------------------------------
  always_comb begin
    for (int j = 0; j < BINS-1; j++) begin
      upper[j] = edge_val[j+1];
    end
    // Last bin extrapolated with the first bin's width, wraps mod 2^32
    upper[BINS-1] = edge_val[BINS-1] + edge_val[1] - edge_val[0];
  end

  // Lane in bin j when edge_j < v <= upper_j, unsigned
  always_comb begin
    for (int j = 0; j < BINS; j++) begin
      for (int i = 0; i < LANES; i++) begin
        match[j][i] = (beat[i] > edge_val[j]) && (beat[i] <= upper[j]);
      end
    end
  end

endmodule

/* logic/match_reduce.sv */
/*
 * Match matrix reduce
 * Orients the bin match matrix by axis, registers it and counts each row
 */
`timescale 1ns/1ps

module match_reduce (
  input  logic                                          clk,
  input  logic [fru_pkg::BINS-1:0][fru_pkg::LANES-1:0]  match,
  input  fru_pkg::cfg_byte_t                            axis,
  output fru_pkg::count_t                               counts [fru_pkg::LANES-1:0]
);
  import fru_pkg::*;

  logic [LANES-1:0][LANES-1:0] rows_d;
  logic [LANES-1:0][LANES-1:0] rows_q;

  // One-bit adder tree in heap order, leaves at LANES..2*LANES-1
  function automatic count_t count_ones(input logic [LANES-1:0] bits);
    count_t part [2*LANES];
    for (int k = 0; k < LANES; k++) begin
      part[LANES+k] = count_t'(bits[k]);
    end
    for (int n = LANES-1; n > 0; n--) begin
      part[n] = part[2*n] + part[2*n+1];
    end
    return part[1];
  endfunction

  // ----------------------------------------------------------------------
  // Axis selection
  // ----------------------------------------------------------------------
  always_comb begin
    rows_d = '0;
    if (axis == AXIS_PER_BIN) begin
      // Row i counts lanes hitting bin i, rows past BINS stay empty
      for (int i = 0; i < BINS; i++) begin
        for (int j = 0; j < LANES; j++) begin
          rows_d[i][j] = match[i][j];
        end
      end
    end else begin
      // Row i counts bins hit by lane i
      for (int i = 0; i < LANES; i++) begin
        for (int j = 0; j < BINS; j++) begin
          rows_d[i][j] = match[j][i];
        end
      end
    end
  end

  always_ff @(posedge clk) begin
    rows_q <= rows_d;
  end

  always_comb begin
    for (int i = 0; i < LANES; i++) begin
      counts[i] = count_ones(rows_q[i]);
    end
  end

endmodule

/* logic/filter_reduce_unit.sv */
/*
 * Filter-reduce unit
 * Three-stage trace beat pipeline, histogram or per-lane bin counts
 * on the reduce path, plain pass-through otherwise
 */
`timescale 1ns/1ps

module filter_reduce_unit (
  input  logic                clk,
  input  logic                reset,
  input  logic                tracing,
  input  logic                valid_in,
  input  fru_pkg::marker_t    bof_in,
  input  fru_pkg::marker_t    eof_in,
  input  fru_pkg::chain_id_t  chain_id_in,
  input  fru_pkg::cfg_byte_t  config_id,
  input  fru_pkg::cfg_byte_t  config_data,
  input  fru_pkg::data_t      vector_in [fru_pkg::LANES-1:0],
  output fru_pkg::data_t      vector_out [fru_pkg::LANES-1:0],
  output fru_pkg::chain_id_t  chain_id_out,
  output logic                valid_out,
  output fru_pkg::marker_t    bof_out,
  output fru_pkg::marker_t    eof_out
);
  import fru_pkg::*;

  // Table lookups for the incoming chain
  cfg_byte_t  cfg_op;
  cfg_byte_t  cfg_edge_addr;
  cfg_byte_t  cfg_axis;

  // Edge memory
  logic       edge_wr_en;
  edge_addr_t edge_wr_addr;
  edge_row_t  edge_wr_row;
  edge_addr_t edge_rd_addr;
  edge_row_t  edge_row;

  // Stage 1
  logic       valid_s1;
  data_t      beat_s1 [LANES-1:0];
  marker_t    bof_s1;
  marker_t    eof_s1;
  chain_id_t  chain_s1;
  cfg_byte_t  op_s1;
  cfg_byte_t  axis_s1;

  // Stage 2
  logic       valid_s2;
  data_t      beat_s2 [LANES-1:0];
  marker_t    bof_s2;
  marker_t    eof_s2;
  chain_id_t  chain_s2;
  cfg_byte_t  op_s2;

  logic [BINS-1:0][LANES-1:0] match;
  count_t     counts [LANES-1:0];
  data_t      result_vec [LANES-1:0];

  // ----------------------------------------------------------------------
  // Configuration and edge memory
  // ----------------------------------------------------------------------
  fru_config_loader fru_config_loader_i (
    .clk          (clk),
    .reset        (reset),
    .tracing      (tracing),
    .config_id    (config_id),
    .config_data  (config_data),
    .lookup_chain (chain_id_in),
    .filter_op    (cfg_op),
    .edge_addr    (cfg_edge_addr),
    .reduce_axis  (cfg_axis),
    .edge_wr_en   (edge_wr_en),
    .edge_wr_addr (edge_wr_addr),
    .edge_wr_row  (edge_wr_row)
  );

  // Row address follows the beat, so the row lands alongside stage 1
  assign edge_rd_addr = edge_addr_t'(cfg_edge_addr);

  bin_edge_ram bin_edge_ram_i (
    .clk     (clk),
    .rd_addr (edge_rd_addr),
    .rd_row  (edge_row),
    .wr_en   (edge_wr_en),
    .wr_addr (edge_wr_addr),
    .wr_row  (edge_wr_row)
  );

  // ----------------------------------------------------------------------
  // Filter and reduce
  // ----------------------------------------------------------------------
  bin_filter bin_filter_i (
    .beat  (beat_s1),
    .edges (edge_row),
    .match (match)
  );

  // Matrix register inside forms stage 2
  match_reduce match_reduce_i (
    .clk    (clk),
    .match  (match),
    .axis   (axis_s1),
    .counts (counts)
  );

  // ----------------------------------------------------------------------
  // Delay pipeline
  // ----------------------------------------------------------------------
  always_ff @(posedge clk) begin
    if (reset) begin
      valid_s1 <= 1'b0;
      valid_s2 <= 1'b0;
    end else begin
      valid_s1 <= valid_in;
      valid_s2 <= valid_s1;
    end
  end

  always_ff @(posedge clk) begin
    beat_s1  <= vector_in;
    bof_s1   <= bof_in;
    eof_s1   <= eof_in;
    chain_s1 <= chain_id_in;
    op_s1    <= cfg_op;
    axis_s1  <= cfg_axis;

    beat_s2  <= beat_s1;
    bof_s2   <= bof_s1;
    eof_s2   <= eof_s1;
    chain_s2 <= chain_s1;
    op_s2    <= op_s1;
  end

  // Counts on the reduce path, words untouched otherwise
  always_comb begin
    for (int i = 0; i < LANES; i++) begin
      result_vec[i] = (op_s2 == OP_REDUCE) ? data_t'(counts[i]) : beat_s2[i];
    end
  end

  // ----------------------------------------------------------------------
  // Output stage
  // ----------------------------------------------------------------------
  always_ff @(posedge clk) begin
    if (reset) begin
      valid_out <= 1'b0;
    end else begin
      valid_out <= tracing && valid_s2;
    end
  end

  // Outputs hold while configuring
  always_ff @(posedge clk) begin
    if (tracing) begin
      vector_out   <= result_vec;
      chain_id_out <= chain_s2;
      bof_out      <= bof_s2;
      eof_out      <= eof_s2;
    end
  end

endmodule

/* dv/filter_reduce_unit_tb.sv */
/*
 * Filter-reduce unit testbench
 * Replays the stimulus file into the DUT and checks every valid output
 */
`timescale 1ns/1ps

module filter_reduce_unit_tb;
  import fru_pkg::*;

  logic      clk = 1'b0;
  logic      reset;
  logic      tracing;
  logic      valid_in;
  marker_t   bof_in;
  marker_t   eof_in;
  chain_id_t chain_id_in;
  cfg_byte_t config_id;
  cfg_byte_t config_data;
  data_t     vector_in [LANES-1:0];
  data_t     vector_out [LANES-1:0];
  chain_id_t chain_id_out;
  logic      valid_out;
  marker_t   bof_out;
  marker_t   eof_out;

  // Expected results in beat order
  chain_id_t                   exp_chain [$];
  marker_t                     exp_bof [$];
  marker_t                     exp_eof [$];
  logic [LANES*DATA_WIDTH-1:0] exp_words [$];
  int unsigned                 beat_edge [$];

  int unsigned cycle = 0;
  int          checks = 0;
  int          errors = 0;

  filter_reduce_unit filter_reduce_unit_i (
    .clk          (clk),
    .reset        (reset),
    .tracing      (tracing),
    .valid_in     (valid_in),
    .bof_in       (bof_in),
    .eof_in       (eof_in),
    .chain_id_in  (chain_id_in),
    .config_id    (config_id),
    .config_data  (config_data),
    .vector_in    (vector_in),
    .vector_out   (vector_out),
    .chain_id_out (chain_id_out),
    .valid_out    (valid_out),
    .bof_out      (bof_out),
    .eof_out      (eof_out)
  );

  always #50 clk = ~clk;

  always @(posedge clk) begin
    cycle <= cycle + 1;
  end

  // ----------------------------------------------------------------------
  // Compare tasks
  // ----------------------------------------------------------------------
  task automatic check_data(input string name, input data_t got, input data_t exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("ERR %s got %h expected %h", name, got, exp);
    end
  endtask

  task automatic check_chain(input chain_id_t got, input chain_id_t exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("ERR chain_id_out got %h expected %h", got, exp);
    end
  endtask

  task automatic check_marker(input string name, input marker_t got, input marker_t exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("ERR %s got %h expected %h", name, got, exp);
    end
  endtask

  // Outputs settle after the rising edge, sampled on the falling one
  always @(negedge clk) begin : monitor
    logic [LANES*DATA_WIDTH-1:0] words;
    int unsigned                 latency;
    if (valid_out === 1'b1) begin
      if (exp_chain.size() == 0 || beat_edge.size() == 0) begin
        errors++;
        $display("extra valid output at cycle %0d while no result was pending", cycle);
      end else begin
        latency = cycle - beat_edge.pop_front();
        checks++;
        if (latency != 3) begin
          errors++;
          $display("result came %0d cycles after its beat instead of 3", latency);
        end
        words = exp_words.pop_front();
        check_chain(chain_id_out, exp_chain.pop_front());
        check_marker("bof_out", bof_out, exp_bof.pop_front());
        check_marker("eof_out", eof_out, exp_eof.pop_front());
        for (int i = 0; i < LANES; i++) begin
          check_data($sformatf("vector_out[%0d]", i), vector_out[i],
                     words[i*DATA_WIDTH +: DATA_WIDTH]);
        end
      end
    end
  end

  // ----------------------------------------------------------------------
  // Stimulus replay
  // ----------------------------------------------------------------------
  initial begin : driver
    int                          fd;
    int                          r;
    int                          n;
    int                          wait_cycles;
    int                          test_errors;
    logic [7:0]                  kind;
    logic [8*32-1:0]             name;
    logic [8*120-1:0]            line;
    logic                        tr;
    cfg_byte_t                   id;
    cfg_byte_t                   b;
    chain_id_t                   ch;
    marker_t                     bf;
    marker_t                     ef;
    data_t                       w;
    logic [LANES*DATA_WIDTH-1:0] words;
    // Valid beats during reset must not come out
    reset       = 1'b1;
    tracing     = 1'b1;
    valid_in    = 1'b1;
    bof_in      = '0;
    eof_in      = '0;
    chain_id_in = '0;
    config_id   = 8'hff;
    config_data = '0;
    vector_in   = '{default: '0};
    test_errors = 0;
    repeat (8) @(posedge clk);
    @(negedge clk);
    reset    = 1'b0;
    valid_in = 1'b0;
    tracing  = 1'b0;
    fd = $fopen("dv/fru_stimulus.txt", "r");
    if (fd == 0) begin
      $display("cannot open stimulus file dv/fru_stimulus.txt");
      $display("CHECKS FAILED");
      $finish;
    end else begin
      while ($fscanf(fd, "%s", kind) == 1) begin
        case (kind)
          "#": r = $fgets(line, fd);
          "C": begin
            r = $fscanf(fd, "%h %d", id, n);
            repeat (n) begin
              r = $fscanf(fd, "%h", b);
              @(negedge clk);
              tracing     = 1'b0;
              valid_in    = 1'b0;
              config_id   = id;
              config_data = b;
            end
          end
          "I": begin
            r = $fscanf(fd, "%h %d", tr, n);
            repeat (n) begin
              @(negedge clk);
              tracing   = tr;
              valid_in  = 1'b0;
              config_id = 8'hff;
            end
          end
          "B", "E": begin
            if (kind == "B") begin
              r = $fscanf(fd, "%h", tr);
            end
            r = $fscanf(fd, "%h %h %h", ch, bf, ef);
            for (int i = 0; i < LANES; i++) begin
              r = $fscanf(fd, "%h", w);
              words[i*DATA_WIDTH +: DATA_WIDTH] = w;
            end
            if (kind == "E") begin
              exp_chain.push_back(ch);
              exp_bof.push_back(bf);
              exp_eof.push_back(ef);
              exp_words.push_back(words);
            end else begin
              @(negedge clk);
              // Cycle in which the beat sits on the inputs
              if (tr) begin
                beat_edge.push_back(cycle);
              end
              tracing     = tr;
              valid_in    = 1'b1;
              config_id   = 8'hff;
              chain_id_in = ch;
              bof_in      = bf;
              eof_in      = ef;
              for (int i = 0; i < LANES; i++) begin
                vector_in[i] = words[i*DATA_WIDTH +: DATA_WIDTH];
              end
            end
          end
          "D": begin
            r = $fscanf(fd, "%s", name);
            @(negedge clk);
            valid_in    = 1'b0;
            config_id   = 8'hff;
            wait_cycles = 0;
            while (exp_chain.size() != 0 && wait_cycles < 20) begin
              @(posedge clk);
              wait_cycles++;
            end
            if (exp_chain.size() != 0) begin
              errors++;
              $display("%0d expected results never appeared", exp_chain.size());
              exp_chain.delete();
              exp_bof.delete();
              exp_eof.delete();
              exp_words.delete();
            end
            beat_edge.delete();
            if (errors == test_errors) begin
              $display("test %0s: ok", name);
            end else begin
              $display("test %0s: %0d errors", name, errors - test_errors);
            end
            test_errors = errors;
          end
          default: begin
            errors++;
            $display("unknown record kind %s in stimulus file", kind);
            r = $fgets(line, fd);
          end
        endcase
      end
      $fclose(fd);
      $display("%0d checks, %0d errors", checks, errors);
      if (errors == 0) begin
        $display("ALL CHECKS PASSED");
      end else begin
        $display("CHECKS FAILED");
      end
      $finish;
    end
  end

endmodule

/* dv/fru_stimulus.txt */
# C id(hex) count(dec) bytes(hex) | I tracing cycles(dec) | D test_name
# B tracing chain bof eof w0..w7 drives a beat | E chain bof eof w0..w7 expects an output
B 0 0 1 2 11111111 22222222 33333333 44444444 55555555 66666666 77777777 88888888
B 0 1 0 0 00000015 00000020 00000021 00000035 00000045 00000050 00000051 00000005
I 0 4
D quiet_until_tracing
C 00 12 00 01 01 01 00 00 01 02 00 02 00 02
C 00 16 00 00 00 10 00 00 00 20 00 00 00 30 00 00 00 40
C 00 16 00 00 01 00 00 00 01 80 00 00 02 00 00 00 02 80
C 00 16 00 00 10 00 00 00 20 00 00 00 30 00 00 00 40 00
C 00 16 00 00 00 00 00 00 00 01 00 00 00 02 00 00 00 03
I 1 2
D load_config
B 1 0 1 2 0badf00d 12345678 9abcdef0 00000000 ffffffff 00000015 00000035 80000001
E 0 1 2 0badf00d 12345678 9abcdef0 00000000 ffffffff 00000015 00000035 80000001
D pass_through
B 1 1 3 0 00000015 00000020 00000021 00000035 00000045 00000050 00000051 00000005
E 1 3 0 00000002 00000001 00000001 00000002 00000000 00000000 00000000 00000000
D per_bin_histogram
B 1 2 0 3 00000100 00000101 00000180 00000181 00000280 000002ff 00000300 00000301
E 2 0 3 00000000 00000001 00000001 00000001 00000001 00000001 00000001 00000000
D per_lane_counts
C 00 2 00 01
I 0 1
C 05 4 00 00 00 00
C 00 1 00
I 1 2
B 1 2 1 1 00000100 00000101 00000180 00000181 00000280 000002ff 00000300 00000301
E 2 1 1 00000000 00000001 00000001 00000001 00000001 00000001 00000001 00000000
B 1 0 2 0 00000015 00000020 00000021 00000035 00000045 00000050 00000051 00000005
E 0 2 0 00000015 00000020 00000021 00000035 00000045 00000050 00000051 00000005
D config_guard
C 00 12 01 01 01 01 03 00 01 02 00 02 00 02
I 1 1
B 1 0 2 1 00000000 00000001 00000002 00000003 00000004 00000005 00000001 00000002
E 0 2 1 00000000 00000001 00000001 00000001 00000001 00000000 00000001 00000001
D config_rewrite
B 1 1 1 0 00000015 00000020 00000021 00000035 00000045 00000050 00000051 00000005
E 1 1 0 00000002 00000001 00000001 00000002 00000000 00000000 00000000 00000000
B 1 2 0 1 00000100 00000101 00000180 00000181 00000280 000002ff 00000300 00000301
E 2 0 1 00000000 00000001 00000001 00000001 00000001 00000001 00000001 00000000
B 1 3 2 2 00001000 00001001 00002000 00002fff 00003000 00004001 00005000 00005001
E 3 2 2 00000002 00000002 00000000 00000002 00000000 00000000 00000000 00000000
B 1 0 3 3 00000000 00000001 00000002 00000003 00000004 00000005 00000001 00000002
E 0 3 3 00000000 00000001 00000001 00000001 00000001 00000000 00000001 00000001
D back_to_back

/* compile.f */
logic/fru_pkg.sv
logic/bin_edge_ram.sv
logic/fru_config_loader.sv
logic/bin_filter.sv
logic/match_reduce.sv
logic/filter_reduce_unit.sv
dv/filter_reduce_unit_tb.sv

/* Makefile */
SIM      = verilator
FLAGS    = --binary --timing
TOP      = filter_reduce_unit_tb
FILELIST = compile.f
LOG      = sim.log
PASS_MSG = ALL CHECKS PASSED

.PHONY: help test clean

help:
	@echo "make test   build and run the testbench, pass or fail from $(LOG)"
	@echo "make clean  remove the build directory and the log"
	@echo "make help   show this list"

test:
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST) -o $(TOP)
	./obj_dir/$(TOP) | tee $(LOG)
	grep -q "$(PASS_MSG)" $(LOG)

clean:
	rm -rf obj_dir $(LOG)
